//--- build_sim.sh
#!/bin/sh
# compile the UART testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
	--top-module uart_loop_tb \
	-f uart_loop.f \
	-o uart_loop_sim

./obj_dir/uart_loop_sim > sim.log 2>&1
cat sim.log

if grep -q "all tests passed" sim.log; then
	echo "simulation PASS"
else
	echo "simulation FAIL"
	exit 1
fi

//--- hw/uart_baud_gen.sv
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_baud_gen (
	input logic clk,
	input logic reset,
	output logic o_tick // one cycle pulse per bit period
);

	localparam int CLKS_PER_BIT = `UART_CLKS_PER_BIT;
	localparam int CNT_W = $clog2(CLKS_PER_BIT);

	logic [CNT_W-1:0] cnt_q; // position inside the current bit period

	always_ff @(posedge clk) begin
		if (reset) begin
			cnt_q <= '0;
		end else if (cnt_q == CNT_W'(CLKS_PER_BIT - 1)) begin
			cnt_q <= '0; // wrap, explicit so non power of two values work
		end else begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	// free running, the tx decides whether a tick matters
	assign o_tick = (cnt_q == CNT_W'(CLKS_PER_BIT - 1));

endmodule

//--- hw/uart_config.svh
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// frame format, shared by rtl and testbench
`define UART_DATA_BITS 8 // data bits per frame
`define UART_PARITY_EN 1 // 1 inserts a parity bit after the data
`define UART_PARITY_ODD 0 // 0 even, 1 odd

// bit timing
`define UART_CLKS_PER_BIT 8 // clk cycles per serial bit, keep it at 4 or more

// start + data + parity + stop
`define UART_FRAME_BITS (1 + `UART_DATA_BITS + `UART_PARITY_EN + 1)

`endif

//--- hw/uart_loop_top.sv
`timescale 1ns/1ps

module uart_loop_top import uart_pkg::*; (
	input logic clk,
	input logic reset,

	// transmit side
	input logic i_enable, // start a frame when idle
	input uart_data_t i_data,
	output logic o_busy,
	output logic o_serial,

	// receive side, kept apart so the loop is closed outside
	input logic i_serial,
	output uart_data_t o_rx_data,
	output logic o_rx_valid,
	output logic o_rx_error
);

	logic tick; // bit boundary, only the tx needs it

	uart_baud_gen u_baud_gen (
		.clk (clk),
		.reset (reset),
		.o_tick (tick)
	);

	uart_tx u_tx (
		.clk (clk),
		.reset (reset),
		.i_tick (tick),
		.i_enable (i_enable),
		.i_data (i_data),
		.o_busy (o_busy),
		.o_serial (o_serial)
	);

	// rx times itself from the start edge, no tick here
	uart_rx u_rx (
		.clk (clk),
		.reset (reset),
		.i_serial (i_serial),
		.o_rx_data (o_rx_data),
		.o_rx_valid (o_rx_valid),
		.o_rx_error (o_rx_error)
	);

endmodule

//--- hw/uart_pkg.sv
`include "uart_config.svh"

package uart_pkg;

	// one data word as it travels over the link
	typedef logic [`UART_DATA_BITS-1:0] uart_data_t;

	// transmitter states
	typedef enum logic [1:0] {
		TX_IDLE, // line high, waiting for i_enable
		TX_ARMED, // frame loaded, waiting for the first bit tick
		TX_SEND // shifting the frame out, one bit per tick
	} tx_state_e;

	// receiver states
	typedef enum logic [2:0] {
		RX_IDLE, // watching for the falling start edge
		RX_START, // counting to the middle of the start bit
		RX_DATA, // sampling data bits lsb first
		RX_PARITY, // sampling the parity bit
		RX_STOP // sampling the stop bit, then reporting
	} rx_state_e;

endpackage

//--- hw/uart_rx.sv
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_rx import uart_pkg::*; (
	input logic clk,
	input logic reset,
	input logic i_serial, // asynchronous line
	output uart_data_t o_rx_data, // last word received, held until the next one
	output logic o_rx_valid, // one cycle pulse at the stop bit mid-point
	output logic o_rx_error // parity or stop error, same cycle as valid
);

	localparam int DATA_BITS = `UART_DATA_BITS;
	localparam int CLKS_PER_BIT = `UART_CLKS_PER_BIT;
	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	localparam int IDX_W = (DATA_BITS > 1) ? $clog2(DATA_BITS) : 1;

	rx_state_e state_q;
	logic [2:0] sync_q; // three flop synchronizer, bit 2 is the clean copy
	logic rx_bit; // synchronized line
	logic rx_prev; // line one cycle earlier, for the falling edge
	logic start_edge;
	logic [CNT_W-1:0] cnt_q; // cycles left until the next sample point
	logic [IDX_W-1:0] bit_idx_q; // data bit being sampled
	uart_data_t data_q; // shift in from the top, lsb arrives first
	logic parity_q; // running xor of the sampled data
	logic par_err_q; // parity mismatch seen in this frame
	logic sample; // mid-bit sample point

	assign rx_bit = sync_q[2];
	assign start_edge = rx_prev & ~rx_bit;
	assign sample = (cnt_q == '0);

	// synchronizer and edge history, held at mark through reset
	always_ff @(posedge clk) begin
		if (reset) begin
			sync_q <= 3'b111;
			rx_prev <= 1'b1;
		end else begin
			sync_q <= {sync_q[1:0], i_serial};
			rx_prev <= rx_bit;
		end
	end

	// receive FSM
	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= RX_IDLE;
			cnt_q <= '0;
			bit_idx_q <= '0;
			o_rx_valid <= 1'b0;
			o_rx_error <= 1'b0;
		end else begin
			o_rx_valid <= 1'b0; // pulses by default
			o_rx_error <= 1'b0;
			unique case (state_q)
				RX_IDLE: begin
					if (start_edge) begin
						cnt_q <= CNT_W'(CLKS_PER_BIT / 2 - 1); // aim at mid start bit
						state_q <= RX_START;
					end
				end
				RX_START: begin
					if (!sample) begin
						cnt_q <= cnt_q - 1'b1;
					end else if (!rx_bit) begin
						cnt_q <= CNT_W'(CLKS_PER_BIT - 1); // one full bit to next centre
						bit_idx_q <= '0;
						state_q <= RX_DATA;
					end else begin
						state_q <= RX_IDLE; // line went back high, a glitch
					end
				end
				RX_DATA: begin
					if (!sample) begin
						cnt_q <= cnt_q - 1'b1;
					end else begin
						cnt_q <= CNT_W'(CLKS_PER_BIT - 1);
						bit_idx_q <= bit_idx_q + 1'b1;
						if (bit_idx_q == IDX_W'(DATA_BITS - 1)) begin
							// parity state only exists when enabled
							state_q <= (`UART_PARITY_EN != 0) ? RX_PARITY : RX_STOP;
						end
					end
				end
				RX_PARITY: begin
					if (!sample) begin
						cnt_q <= cnt_q - 1'b1;
					end else begin
						cnt_q <= CNT_W'(CLKS_PER_BIT - 1);
						state_q <= RX_STOP;
					end
				end
				RX_STOP: begin
					if (!sample) begin
						cnt_q <= cnt_q - 1'b1;
					end else begin
						o_rx_valid <= 1'b1;
						o_rx_error <= par_err_q | ~rx_bit; // stop must read as a mark
						state_q <= RX_IDLE; // re-arm at once for a back to back frame
					end
				end
				default: begin
					state_q <= RX_IDLE;
				end
			endcase
		end
	end

	// datapath, loaded only at sample points
	always_ff @(posedge clk) begin
		if (state_q == RX_START && sample) begin
			parity_q <= 1'b0; // fresh frame
			par_err_q <= 1'b0;
		end
		if (state_q == RX_DATA && sample) begin
			data_q <= {rx_bit, data_q[DATA_BITS-1:1]};
			parity_q <= parity_q ^ rx_bit;
		end
		if (state_q == RX_PARITY && sample) begin
			par_err_q <= (parity_q ^ 1'(`UART_PARITY_ODD)) != rx_bit;
		end
		if (state_q == RX_STOP && sample) begin
			o_rx_data <= data_q; // overwrites any unread word
		end
	end

endmodule

//--- hw/uart_tx.sv
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_tx import uart_pkg::*; (
	input logic clk,
	input logic reset,
	input logic i_tick, // bit boundary from the baud generator
	input logic i_enable, // level, only looked at while idle
	input uart_data_t i_data, // captured in the cycle the enable is taken
	output logic o_busy,
	output logic o_serial // registered line, idles high
);

	localparam int DATA_BITS = `UART_DATA_BITS;
	localparam int FRAME_BITS = `UART_FRAME_BITS;
	localparam int BIT_CNT_W = $clog2(FRAME_BITS + 1);

	tx_state_e state_q;
	logic [FRAME_BITS-1:0] shift_q; // frame still to go out, bit 0 is next
	logic [BIT_CNT_W-1:0] bit_cnt_q; // bits already driven onto the line
	logic [FRAME_BITS-1:0] frame_w; // frame built from i_data
	logic parity_bit; // xor of data, inverted for odd parity

	assign parity_bit = (^i_data) ^ 1'(`UART_PARITY_ODD);

	// layout from lsb: start, data lsb first, parity, stop
	always_comb begin
		frame_w = '1; // stop bit sits in the msb
		frame_w[0] = 1'b0; // start bit
		frame_w[DATA_BITS:1] = i_data;
		if (`UART_PARITY_EN != 0) begin
			frame_w[DATA_BITS+1] = parity_bit; // slot just below the stop bit
		end
	end

	// control path
	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= TX_IDLE;
			o_busy <= 1'b0;
			o_serial <= 1'b1; // idle line is a mark
			bit_cnt_q <= '0;
		end else begin
			unique case (state_q)
				TX_IDLE: begin
					o_serial <= 1'b1;
					if (i_enable) begin
						state_q <= TX_ARMED; // wait for the next bit boundary
						o_busy <= 1'b1;
						bit_cnt_q <= '0;
					end
				end
				TX_ARMED: begin
					if (i_tick) begin
						o_serial <= shift_q[0]; // start bit goes out
						bit_cnt_q <= BIT_CNT_W'(1);
						state_q <= TX_SEND;
					end
				end
				TX_SEND: begin
					if (i_tick) begin
						if (bit_cnt_q == BIT_CNT_W'(FRAME_BITS)) begin
							// stop bit has had its full period
							state_q <= TX_IDLE;
							o_busy <= 1'b0;
							o_serial <= 1'b1;
						end else begin
							o_serial <= shift_q[0];
							bit_cnt_q <= bit_cnt_q + 1'b1;
						end
					end
				end
				default: begin
					state_q <= TX_IDLE;
					o_busy <= 1'b0;
					o_serial <= 1'b1;
				end
			endcase
		end
	end

	// frame shift register, payload only
	always_ff @(posedge clk) begin
		if (state_q == TX_IDLE && i_enable) begin
			shift_q <= frame_w; // load on accept
		end else if (state_q != TX_IDLE && i_tick) begin
			shift_q <= {1'b1, shift_q[FRAME_BITS-1:1]}; // fill with mark
		end
	end

endmodule

//--- tb/uart_tb_model.svh
`ifndef UART_TB_MODEL_SVH
`define UART_TB_MODEL_SVH

// galois lfsr, right shifting, taps 32 31 29 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	logic [31:0] n;
	n = s >> 1;
	if (s[0]) begin
		n = n ^ 32'hd000_0001;
	end
	return n;
endfunction

// one lfsr step per bit taken, first bit ends up in the msb of the result
function automatic logic [31:0] take_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		lfsr_q = lfsr_next(lfsr_q);
		v = {v[30:0], lfsr_q[0]};
	end
	return v;
endfunction

// xor over the data word, inverted for odd parity
function automatic logic model_parity(input uart_data_t d);
	logic p;
	p = ^d;
	if (`UART_PARITY_ODD != 0) begin
		p = ~p;
	end
	return p;
endfunction

// frame as it goes on the line, bit 0 first
function automatic logic [`UART_FRAME_BITS-1:0] model_frame(input uart_data_t d,
		input logic flip_par, input logic bad_stop);
	logic [`UART_FRAME_BITS-1:0] f;
	f = '1;
	f[0] = 1'b0; // start
	f[`UART_DATA_BITS:1] = d; // lsb first
	if (`UART_PARITY_EN != 0) begin
		f[`UART_DATA_BITS+1] = model_parity(d) ^ flip_par;
	end
	f[`UART_FRAME_BITS-1] = ~bad_stop; // stop bit, normally a mark
	return f;
endfunction

// bit-bang one frame onto i_serial and queue what the rx must report
task automatic drive_frame(input uart_data_t d, input logic flip_par, input logic bad_stop);
	logic [`UART_FRAME_BITS-1:0] f;
	f = model_frame(d, flip_par, bad_stop);
	exp_data_q.push_back(d);
	exp_err_q.push_back((flip_par && (`UART_PARITY_EN != 0)) || bad_stop);
	for (int b = 0; b < `UART_FRAME_BITS; b++) begin
		@(posedge clk);
		#1;
		drv_serial = f[0];
		f = f >> 1;
		repeat (`UART_CLKS_PER_BIT - 1) @(posedge clk); // hold a full bit
	end
	@(posedge clk);
	#1;
	drv_serial = 1'b1; // back to idle mark
endtask

// short low pulse, too short to be a start bit
task automatic drive_glitch(input int low_cycles);
	@(posedge clk);
	#1;
	drv_serial = 1'b0;
	repeat (low_cycles) @(posedge clk);
	#1;
	drv_serial = 1'b1;
endtask

task automatic check_data(input string name, input uart_data_t exp, input uart_data_t act);
	if (act !== exp) begin
		$display("MISMATCH t=%0t %s expected %h actual %h", $time, name, exp, act);
		err_cnt++;
	end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
	if (act !== exp) begin
		$display("MISMATCH t=%0t %s expected %b actual %b", $time, name, exp, act);
		err_cnt++;
	end
endtask

task automatic check_count(input string name, input int exp, input int act);
	if (act != exp) begin
		$display("MISMATCH t=%0t %s expected %0d actual %0d", $time, name, exp, act);
		err_cnt++;
	end
endtask

task automatic report_error(input string msg);
	$display("ERROR t=%0t %s", $time, msg);
	err_cnt++;
endtask

`endif

//--- tb/uart_loop_tb.sv
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_loop_tb import uart_pkg::*; ();

	localparam int CPB = `UART_CLKS_PER_BIT;
	localparam int FRAME_BITS = `UART_FRAME_BITS;
	localparam int FRAME_CYCLES = FRAME_BITS * CPB; // one frame on the line
	localparam logic [31:0] SEED = 32'hc4f1f7a0;
	localparam int N_LOOP = 40;
	localparam int N_BUSY = 5;
	localparam int N_B2B = 8;
	localparam int N_FAULT = 20;
	localparam int TOTAL_FRAMES = N_LOOP + N_BUSY + N_B2B + N_FAULT + 1; // last one after glitch
	localparam int TIMEOUT_CYCLES = TOTAL_FRAMES * (FRAME_BITS + 2) * CPB * 2 + 100;

	logic clk;
	logic reset;
	logic i_enable;
	uart_data_t i_data;
	logic o_busy;
	logic o_serial;
	logic serial_in; // what the rx actually sees
	uart_data_t o_rx_data;
	logic o_rx_valid;
	logic o_rx_error;

	logic use_driver; // 0 loopback, 1 bit-bang driver
	logic drv_serial;
	logic [31:0] lfsr_q;

	uart_data_t exp_data_q[$]; // words the rx still owes us
	logic exp_err_q[$];
	int start_q[$]; // cycle of each loopback start bit

	int cycle_cnt = 0;
	int err_cnt = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int valid_cnt = 0;
	int accept_cnt = 0;
	int busy_len = 0;
	logic accept_pending = 1'b0;
	logic frame_started = 1'b0;

	`include "uart_tb_model.svh"

	assign serial_in = use_driver ? drv_serial : o_serial;

	uart_loop_top DUT (
		.clk (clk),
		.reset (reset),
		.i_enable (i_enable),
		.i_data (i_data),
		.o_busy (o_busy),
		.o_serial (o_serial),
		.i_serial (serial_in),
		.o_rx_data (o_rx_data),
		.o_rx_valid (o_rx_valid),
		.o_rx_error (o_rx_error)
	);

	always #10 clk = ~clk; // 20 ns period

	// watchdog
	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("run timed out after %0d cycles, the DUT stopped answering", cycle_cnt);
			$display("tests failed");
			$finish;
		end
	end

	// monitor samples at the falling edge where everything is settled
	always @(negedge clk) begin
		int lat;
		if (!reset) begin
			if (accept_pending) begin
				check_flag("o_busy", 1'b1, o_busy); // must be up after an accept
			end
			accept_pending = i_enable && !o_busy; // tx takes it at the next edge
			if (accept_pending) begin
				exp_data_q.push_back(i_data);
				exp_err_q.push_back(1'b0);
				accept_cnt++;
			end
			if (o_busy) begin
				busy_len++;
			end else begin
				if (busy_len != 0 && busy_len < FRAME_CYCLES) begin
					report_error($sformatf("o_busy high only %0d cycles, a frame needs %0d",
						busy_len, FRAME_CYCLES));
				end
				busy_len = 0;
				frame_started = 1'b0;
			end
			if (!use_driver && o_busy && !frame_started && !o_serial) begin
				frame_started = 1'b1; // first low while busy is the start bit
				start_q.push_back(cycle_cnt);
			end
			if (o_rx_valid) begin
				valid_cnt++;
				if (exp_data_q.size() == 0) begin
					report_error("o_rx_valid pulsed with no frame outstanding");
				end else begin
					check_data("o_rx_data", exp_data_q.pop_front(), o_rx_data);
					check_flag("o_rx_error", exp_err_q.pop_front(), o_rx_error);
				end
				if (start_q.size() != 0) begin
					lat = cycle_cnt - start_q.pop_front();
					if (lat > FRAME_CYCLES + 1) begin // one frame plus a cycle of slack
						report_error($sformatf("o_rx_valid came %0d cycles after the start bit",
							lat));
					end
				end
			end else if (o_rx_error) begin
				report_error("o_rx_error pulsed without o_rx_valid");
			end
		end
	end

	// raise enable and hold it until the tx is idle to take it
	task automatic send_word(input uart_data_t d);
		@(posedge clk);
		#1;
		i_enable = 1'b1;
		i_data = d;
		do begin
			@(negedge clk);
		end while (o_busy);
		@(posedge clk); // taken here
		#1;
		i_enable = 1'b0;
	endtask

	// let the link go quiet and wait a few more bits to catch stray pulses
	task automatic wait_drain();
		do begin
			@(negedge clk);
		end while (exp_data_q.size() != 0 || o_busy);
		repeat (2 * CPB) @(negedge clk);
	endtask

	task automatic close_test(input string name, input int errs_before);
		tests_run++;
		if (err_cnt == errs_before) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: FAIL with %0d errors", name, err_cnt - errs_before);
		end
	endtask

	initial begin
		int errs;
		int valids;
		int accepts;
		logic [1:0] sel;
		clk = 1'b0;
		reset = 1'b1;
		i_enable = 1'b0;
		i_data = '0;
		use_driver = 1'b0;
		drv_serial = 1'b1;
		lfsr_q = SEED;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;

		// reset state with nothing enabled yet
		errs = err_cnt;
		repeat (2 * CPB) begin
			@(negedge clk);
			check_flag("o_serial", 1'b1, o_serial);
			check_flag("o_busy", 1'b0, o_busy);
			check_flag("o_rx_valid", 1'b0, o_rx_valid);
			check_flag("o_rx_error", 1'b0, o_rx_error);
		end
		close_test("reset_state", errs);

		// random words through the loopback with random gaps
		errs = err_cnt;
		valids = valid_cnt;
		for (int k = 0; k < N_LOOP; k++) begin
			repeat (take_bits(4)) @(posedge clk);
			send_word(uart_data_t'(take_bits(`UART_DATA_BITS)));
		end
		wait_drain();
		check_count("o_rx_valid pulses", N_LOOP, valid_cnt - valids);
		close_test("loopback", errs);

		// enable raised again while busy must not add frames
		errs = err_cnt;
		valids = valid_cnt;
		accepts = accept_cnt;
		for (int k = 0; k < N_BUSY; k++) begin
			send_word(uart_data_t'(take_bits(`UART_DATA_BITS)));
			repeat (1 + take_bits(4)) @(posedge clk);
			#1;
			i_enable = 1'b1; // busy now so this is ignored
			i_data = uart_data_t'(take_bits(`UART_DATA_BITS));
			repeat (1 + take_bits(3)) @(posedge clk);
			#1;
			i_enable = 1'b0;
			do begin
				@(negedge clk);
			end while (o_busy);
		end
		wait_drain();
		check_count("accepted enables", N_BUSY, accept_cnt - accepts);
		check_count("o_rx_valid pulses", accept_cnt - accepts, valid_cnt - valids);
		close_test("busy_enable", errs);

		// enable held high with new data after each accept
		errs = err_cnt;
		valids = valid_cnt;
		@(posedge clk);
		#1;
		i_enable = 1'b1;
		i_data = uart_data_t'(take_bits(`UART_DATA_BITS));
		for (int k = 0; k < N_B2B; k++) begin
			do begin
				@(negedge clk);
			end while (o_busy);
			@(posedge clk); // word k taken
			#1;
			if (k == N_B2B - 1) begin
				i_enable = 1'b0;
			end else begin
				i_data = uart_data_t'(take_bits(`UART_DATA_BITS));
			end
		end
		wait_drain();
		check_count("o_rx_valid pulses", N_B2B, valid_cnt - valids);
		close_test("back_to_back", errs);

		// driver frames with some bad parity or stop bits
		errs = err_cnt;
		valids = valid_cnt;
		@(posedge clk);
		#1;
		use_driver = 1'b1;
		for (int k = 0; k < N_FAULT; k++) begin
			sel = 2'(take_bits(2)); // 1 parity flip, 2 stop low, else clean
			drive_frame(uart_data_t'(take_bits(`UART_DATA_BITS)), sel == 2'd1, sel == 2'd2);
			repeat (2 + take_bits(4)) @(posedge clk); // line high again before next start
		end
		wait_drain();
		check_count("o_rx_valid pulses", N_FAULT, valid_cnt - valids);
		close_test("faults", errs);

		// glitch on the line followed by one good frame
		errs = err_cnt;
		valids = valid_cnt;
		drive_glitch(CPB / 4);
		repeat (FRAME_CYCLES + 2 * CPB) @(negedge clk); // a false start reports within a frame
		check_count("o_rx_valid pulses after glitch", 0, valid_cnt - valids);
		drive_frame(uart_data_t'(take_bits(`UART_DATA_BITS)), 1'b0, 1'b0);
		wait_drain();
		check_count("o_rx_valid pulses", 1, valid_cnt - valids);
		@(posedge clk);
		#1;
		use_driver = 1'b0;
		close_test("start_glitch", errs);

		$display("summary: %0d tests run, %0d failing, %0d errors", tests_run, tests_failed,
			err_cnt);
		if (err_cnt == 0 && tests_failed == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

//--- uart_loop.f
+incdir+hw
+incdir+tb
hw/uart_pkg.sv
hw/uart_baud_gen.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_loop_top.sv
tb/uart_loop_tb.sv
